// File: mem_subsys.f
rtl/core_pkg.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/mem_stage.sv
rtl/fetch_unit.sv
rtl/bus_arbiter.sv
rtl/data_ram.sv
rtl/mem_subsys.sv
sim/mem_subsys_chk.sv
sim/mem_subsys_tb.sv

// File: rtl/bus_arbiter.sv
module bus_arbiter (
    input  logic               cache,
    input  logic               rstart,
    input  logic               m0_req_valid,
    input  core_pkg::bus_req_t m0_req,
    output logic               m0_req_ready,
    output logic               m0_rsp_valid,
    output core_pkg::bus_rsp_t m0_rsp,
    input  logic               m1_req_valid,
    input  core_pkg::bus_req_t m1_req,
    output logic               m1_req_ready,
    output logic               m1_rsp_valid,
    output core_pkg::bus_rsp_t m1_rsp,
    output logic               ram_en,
    output core_pkg::bus_req_t ram_req,
    input  core_pkg::word_t    ram_rdata
);

    // last_m1 is both the round-robin pointer and the id of the response due next.
    logic last_m1;
    logic rsp_pend;                                     // a transfer happened last cycle.

    // On a tie the master that did not win the previous transfer goes first.
    assign m0_req_ready = m0_req_valid && (!m1_req_valid || last_m1);
    assign m1_req_ready = m1_req_valid && (!m0_req_valid || !last_m1);

    assign ram_en  = m0_req_ready || m1_req_ready;
    assign ram_req = m1_req_ready ? m1_req : m0_req;

    always_ff @(posedge cache) begin
        if (rstart) begin
            last_m1  <= 1'b1;                           // the memory stage wins the first tie.
            rsp_pend <= 1'b0;
        end else begin
            rsp_pend <= ram_en;
            if (ram_en) begin
                last_m1 <= m1_req_ready;
            end
        end
    end

    assign m0_rsp_valid = rsp_pend && !last_m1;
    assign m1_rsp_valid = rsp_pend && last_m1;
    assign m0_rsp       = '{rdata: ram_rdata};
    assign m1_rsp       = '{rdata: ram_rdata};

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

    localparam int ram_words = 256;                     // depth of the shared data RAM in words.
    localparam int ram_index_bits = $clog2(ram_words);

    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;                         // one bit per byte lane.
    typedef logic [31:0] addr_t;
    typedef logic [ram_index_bits-1:0] ram_index_t;

    // Op codes are fixed so that stimulus files can name them by number.
    typedef enum logic [3:0] {
        mem_none           = 4'd0,
        load_word          = 4'd1,
        load_half          = 4'd2,
        load_byte          = 4'd3,
        load_half_unsigned = 4'd4,
        load_byte_unsigned = 4'd5,
        store_word         = 4'd6,
        store_half         = 4'd7,
        store_byte         = 4'd8
    } mem_op_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;                                   // undefined for write responses.
    } bus_rsp_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {load_word, load_half, load_byte,
                          load_half_unsigned, load_byte_unsigned};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {store_word, store_half, store_byte};
    endfunction

endpackage

// File: rtl/data_ram.sv
module data_ram (
    input  logic               cache,
    input  logic               ram_en,
    input  core_pkg::bus_req_t ram_req,
    output core_pkg::word_t    ram_rdata
);

    core_pkg::word_t      mem [core_pkg::ram_words];
    core_pkg::ram_index_t index;

    // Byte address bits above the RAM size are ignored.
    assign index = ram_req.addr[core_pkg::ram_index_bits+1:2];

    initial begin
        for (int i = 0; i < core_pkg::ram_words; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge cache) begin
        if (ram_en) begin
            if (ram_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (ram_req.wstrb[b]) begin
                        mem[index][8*b +: 8] <= ram_req.wdata[8*b +: 8];
                    end
                end
            end
            ram_rdata <= mem[index];                    // old contents on a write.
        end
    end

endmodule

// File: rtl/fetch_unit.sv
module fetch_unit (
    input  logic               cache,
    input  logic               rstart,
    input  logic               fetch_start,
    input  core_pkg::addr_t    fetch_pc,
    input  logic               fetch_next,
    output logic               instr_valid,
    output core_pkg::word_t    instr,
    output logic               req_valid,
    output core_pkg::bus_req_t req,
    input  logic               req_ready,
    input  logic               rsp_valid,
    input  core_pkg::bus_rsp_t rsp
);

    core_pkg::addr_t pc;
    core_pkg::addr_t pc_next;
    logic            busy;                              // set from request until its response.
    logic            issue;

    // Both strobes are ignored while a word is still outstanding.
    assign issue   = !busy && (fetch_start || fetch_next);
    assign pc_next = fetch_start ? fetch_pc : pc + 32'd4;

    always_ff @(posedge cache) begin
        if (rstart) begin
            pc          <= '0;
            busy        <= 1'b0;
            req_valid   <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= rsp_valid;
            if (issue) begin
                pc        <= pc_next;
                busy      <= 1'b1;
                req_valid <= 1'b1;
            end else begin
                if (req_ready) begin
                    req_valid <= 1'b0;
                end
                if (rsp_valid) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge cache) begin
        if (issue) begin
            req.write <= 1'b0;                          // fetch only ever reads.
            req.addr  <= pc_next;
            req.wdata <= '0;
            req.wstrb <= '0;
        end
        if (rsp_valid) begin
            instr <= rsp.rdata;
        end
    end

endmodule

// File: rtl/load_align.sv
module load_align (
    input  core_pkg::mem_op_t op,
    input  logic [1:0]        addr,
    input  core_pkg::word_t   din,
    output core_pkg::word_t   dout
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = din[8*addr +: 8];
    assign half_sel = addr[1] ? din[31:16] : din[15:0];

    always_comb begin
        case (op)
            core_pkg::load_half: begin
                dout = {{16{half_sel[15]}}, half_sel};
            end
            core_pkg::load_byte: begin
                dout = {{24{byte_sel[7]}}, byte_sel};
            end
            core_pkg::load_half_unsigned: begin
                dout = {16'h0000, half_sel};
            end
            core_pkg::load_byte_unsigned: begin
                dout = {24'h000000, byte_sel};
            end
            default: begin
                // Word loads pass straight through.
                dout = din;
            end
        endcase
    end

endmodule

// File: rtl/mem_stage.sv
module mem_stage (
    input  logic               cache,
    input  logic               rstart,
    input  logic               mem_valid,
    input  core_pkg::mem_op_t  mem_op,
    input  core_pkg::addr_t    mem_addr,
    input  core_pkg::word_t    mem_wdata,
    output logic               mem_ready,
    output logic               mem_done,
    output core_pkg::word_t    mem_rdata,
    output logic               req_valid,
    output core_pkg::bus_req_t req,
    input  logic               req_ready,
    input  logic               rsp_valid,
    input  core_pkg::bus_rsp_t rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_response
    } state_t;

    state_t            state;
    core_pkg::mem_op_t op_q;                            // operation of the access in flight.
    core_pkg::word_t   store_data;
    core_pkg::strb_t   store_strb;
    core_pkg::word_t   load_data;
    logic              accept;

    assign mem_ready = state == st_idle;
    assign accept    = mem_valid && mem_ready;          // strobes outside idle are dropped.

    store_align u_store (
        .op   (mem_op),
        .addr (mem_addr[1:0]),
        .din  (mem_wdata),
        .dout (store_data),
        .strb (store_strb)
    );

    load_align u_load (
        .op   (op_q),
        .addr (req.addr[1:0]),
        .din  (rsp.rdata),
        .dout (load_data)
    );

    always_ff @(posedge cache) begin
        if (rstart) begin
            state     <= st_idle;
            req_valid <= 1'b0;
            mem_done  <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state     <= st_request;
                        req_valid <= 1'b1;
                    end
                end
                st_request: begin
                    if (req_ready) begin                // transfer happens on this edge.
                        state     <= st_response;
                        req_valid <= 1'b0;
                    end
                end
                st_response: begin
                    // Stay one more cycle so mem_ready rises after mem_done.
                    if (mem_done) begin
                        state <= st_idle;
                    end else if (rsp_valid) begin
                        mem_done <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge cache) begin
        if (accept) begin
            op_q      <= mem_op;
            req.write <= core_pkg::is_store(mem_op);
            req.addr  <= mem_addr;
            req.wdata <= store_data;
            req.wstrb <= store_strb;
        end
        if (rsp_valid) begin
            mem_rdata <= core_pkg::is_load(op_q) ? load_data : '0;
        end
    end

endmodule

// File: rtl/mem_subsys.sv
module mem_subsys (
    input  logic              cache,
    input  logic              rstart,
    input  logic              mem_valid,
    input  core_pkg::mem_op_t mem_op,
    input  core_pkg::addr_t   mem_addr,
    input  core_pkg::word_t   mem_wdata,
    output logic              mem_ready,
    output logic              mem_done,
    output core_pkg::word_t   mem_rdata,
    input  logic              fetch_start,
    input  core_pkg::addr_t   fetch_pc,
    input  logic              fetch_next,
    output logic              instr_valid,
    output core_pkg::word_t   instr
);

    logic               m0_req_valid;
    core_pkg::bus_req_t m0_req;
    logic               m0_req_ready;
    logic               m0_rsp_valid;
    core_pkg::bus_rsp_t m0_rsp;
    logic               m1_req_valid;
    core_pkg::bus_req_t m1_req;
    logic               m1_req_ready;
    logic               m1_rsp_valid;
    core_pkg::bus_rsp_t m1_rsp;
    logic               ram_en;
    core_pkg::bus_req_t ram_req;
    core_pkg::word_t    ram_rdata;

    mem_stage m0 (
        .cache     (cache),
        .rstart    (rstart),
        .mem_valid (mem_valid),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .req_valid (m0_req_valid),
        .req       (m0_req),
        .req_ready (m0_req_ready),
        .rsp_valid (m0_rsp_valid),
        .rsp       (m0_rsp)
    );

    fetch_unit m1 (
        .cache       (cache),
        .rstart      (rstart),
        .fetch_start (fetch_start),
        .fetch_pc    (fetch_pc),
        .fetch_next  (fetch_next),
        .instr_valid (instr_valid),
        .instr       (instr),
        .req_valid   (m1_req_valid),
        .req         (m1_req),
        .req_ready   (m1_req_ready),
        .rsp_valid   (m1_rsp_valid),
        .rsp         (m1_rsp)
    );

    bus_arbiter arb (
        .cache        (cache),
        .rstart       (rstart),
        .m0_req_valid (m0_req_valid),
        .m0_req       (m0_req),
        .m0_req_ready (m0_req_ready),
        .m0_rsp_valid (m0_rsp_valid),
        .m0_rsp       (m0_rsp),
        .m1_req_valid (m1_req_valid),
        .m1_req       (m1_req),
        .m1_req_ready (m1_req_ready),
        .m1_rsp_valid (m1_rsp_valid),
        .m1_rsp       (m1_rsp),
        .ram_en       (ram_en),
        .ram_req      (ram_req),
        .ram_rdata    (ram_rdata)
    );

    data_ram ram (
        .cache     (cache),
        .ram_en    (ram_en),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

endmodule

// File: rtl/store_align.sv
module store_align (
    input  core_pkg::mem_op_t op,
    input  logic [1:0]        addr,
    input  core_pkg::word_t   din,
    output core_pkg::word_t   dout,
    output core_pkg::strb_t   strb
);

    always_comb begin
        case (op)
            core_pkg::store_word: begin
                dout = din;
                strb = 4'b1111;
            end
            core_pkg::store_half: begin
                // only addr[1] matters, halves are assumed naturally aligned.
                dout = addr[1] ? din << 16 : din;
                strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            core_pkg::store_byte: begin
                dout = din << {addr, 3'b000};           // move the low byte to its lane.
                strb = 4'b0001 << addr;
            end
            default: begin
                dout = din;
                strb = '0;                              // nothing is written.
            end
        endcase
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the mem_subsys testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f mem_subsys.f --top-module mem_subsys_tb -o sim_mem_subsys
if [ $? -ne 0 ]; then
    echo "build error"
    exit 1
fi

out=$(./obj_dir/sim_mem_subsys 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulator returned status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

// File: sim/mem_patterns.hex
// op addr wdata expected (op: 1-5 loads, 6 word, 7 half, 8 byte store)
6 00000000 11223344 00000000
6 00000004 a5a55a5a 00000000
6 00000008 deadbeef 00000000
1 00000000 00000000 11223344
1 00000004 00000000 a5a55a5a
1 00000008 00000000 deadbeef
8 00000010 000000aa 00000000
8 00000011 000000bb 00000000
8 00000012 000000cc 00000000
8 00000013 000000dd 00000000
1 00000010 00000000 ddccbbaa
7 00000014 00008765 00000000
7 00000016 0000f00f 00000000
1 00000014 00000000 f00f8765
8 00000001 00000099 00000000
1 00000000 00000000 11229944
3 00000010 00000000 ffffffaa
3 00000011 00000000 ffffffbb
5 00000012 00000000 000000cc
5 00000013 00000000 000000dd
2 00000014 00000000 ffff8765
4 00000016 00000000 0000f00f
2 00000016 00000000 fffff00f

// File: sim/mem_subsys_chk.sv
module mem_subsys_chk (
    input logic               cache,
    input logic               rstart,
    input logic               m0_req_valid,
    input core_pkg::bus_req_t m0_req,
    input logic               m0_req_ready,
    input logic               m0_rsp_valid,
    input logic               m1_req_valid,
    input core_pkg::bus_req_t m1_req,
    input logic               m1_req_ready,
    input logic               m1_rsp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    grant_one: assert property (@(posedge cache) disable iff (rstart)
        !(m0_req_ready && m1_req_ready)) else $error("both masters granted");

    // a waiting master must hold its request unchanged.
    hold_m0: assert property (@(posedge cache) disable iff (rstart)
        m0_req_valid && !m0_req_ready |=> m0_req_valid && $stable(m0_req))
        else $error("m0 request changed while waiting");
    hold_m1: assert property (@(posedge cache) disable iff (rstart)
        m1_req_valid && !m1_req_ready |=> m1_req_valid && $stable(m1_req))
        else $error("m1 request changed while waiting");

    rsp_m0: assert property (@(posedge cache) disable iff (rstart)
        m0_req_valid && m0_req_ready |=> m0_rsp_valid) else $error("m0 response missing");
    rsp_m1: assert property (@(posedge cache) disable iff (rstart)
        m1_req_valid && m1_req_ready |=> m1_rsp_valid) else $error("m1 response missing");

endmodule

bind bus_arbiter mem_subsys_chk chk (.*);

// File: sim/mem_subsys_tb.sv
module mem_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_pat   = 23;
    localparam int n_rand  = 30;                         // random loads during fetch traffic.
    localparam int n_fetch = 150;                        // cycles of fetch activity.

    logic              cache = 1'b0;
    logic              rstart;
    logic              mem_valid;
    core_pkg::mem_op_t mem_op;
    core_pkg::addr_t   mem_addr;
    core_pkg::word_t   mem_wdata;
    logic              mem_ready;
    logic              mem_done;
    core_pkg::word_t   mem_rdata;
    logic              fetch_start;
    core_pkg::addr_t   fetch_pc;
    logic              fetch_next;
    logic              instr_valid;
    core_pkg::word_t   instr;

    logic [31:0]     pat [0:4*n_pat-1];
    core_pkg::word_t model [core_pkg::ram_words];
    int              errors = 0;
    int              checks = 0;
    int              done_count = 0;
    int              op_count = 0;
    logic [31:0]     mem_rng = 32'd6365;

    mem_subsys dut (.*);

    always #5 cache = ~cache;

    always @(posedge cache) begin
        if (!rstart && mem_done) done_count++;           // one count per done pulse.
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // value a load should return, from the word it reads.
    function automatic core_pkg::word_t expect_load(logic [3:0] op, logic [1:0] a,
                                                    core_pkg::word_t w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w >> (8 * a);
        h = a[1] ? w[31:16] : w[15:0];
        case (op)
            4'd2: return {{16{h[15]}}, h};
            4'd3: return {{24{b[7]}}, b};
            4'd4: return {16'h0, h};
            4'd5: return {24'h0, b};
            default: return w;
        endcase
    endfunction

    task automatic update_model(logic [3:0] op, core_pkg::addr_t a, core_pkg::word_t d);
        int idx;
        idx = a[9:2];
        for (int i = 0; i < 4; i++) begin
            if (op == 4'd6 || (op == 4'd7 && i[1] == a[1]) || (op == 4'd8 && i == a[1:0]))
                model[idx][8*i +: 8] = (op == 4'd8) ? d[7:0]
                                     : (op == 4'd7) ? d[8*i[0] +: 8] : d[8*i +: 8];
        end
    endtask

    task automatic run_op(logic [3:0] op, core_pkg::addr_t a, core_pkg::word_t d,
                          core_pkg::word_t exp, int max_lat, bit extra);
        int lat;
        lat = 0;
        while (!mem_ready) @(posedge cache);
        mem_valid <= 1'b1;
        mem_op    <= core_pkg::mem_op_t'(op);
        mem_addr  <= a;
        mem_wdata <= d;
        @(posedge cache);                                // acceptance edge.
        mem_valid <= extra;                              // a strobe the stage must ignore.
        op_count++;
        do begin
            @(posedge cache);
            mem_valid <= 1'b0;
            lat++;
        end while (!mem_done && lat < 20);
        checks++;
        if (!mem_done) begin
            errors++;
            $display("no mem_done within 20 cycles for op %0d at %h", op, a);
        end else if (lat - 1 > max_lat || (max_lat == 2 && lat - 1 != 2)) begin
            errors++;
            $display("MISMATCH at %0t: latency %0d, limit %0d", $time, lat - 1, max_lat);
        end
        checks++;
        if (mem_rdata !== exp) begin
            errors++;
            $display("MISMATCH at %0t: op %0d addr %h got %h expected %h",
                     $time, op, a, mem_rdata, exp);
        end
        if (op >= 4'd6) update_model(op, a, d);
    endtask

    task automatic run_patterns(int first, int last);
        core_pkg::word_t ref_val;
        for (int i = first; i <= last; i++) begin
            ref_val = (pat[4*i] >= 6) ? 32'h0
                    : expect_load(pat[4*i][3:0], pat[4*i+1][1:0], model[pat[4*i+1][9:2]]);
            if (ref_val !== pat[4*i+3]) begin
                errors++;
                $display("pattern line %0d disagrees with the reference model", i);
            end
            run_op(pat[4*i][3:0], pat[4*i+1], pat[4*i+2], pat[4*i+3], 2, 1'b0);
        end
    endtask

    task automatic report_test(string name, int start_errors);
        if (errors == start_errors) $display("test %s: ok", name);
        else $display("test %s: FAILED with %0d errors", name, errors - start_errors);
    endtask

    task automatic run_loads_random();
        logic [3:0]  op;
        logic [31:0] a;
        for (int i = 0; i < n_rand; i++) begin
            mem_rng = xorshift(mem_rng);
            op = 4'd1 + mem_rng[2:0] % 5;
            a = {27'd0, mem_rng[12:8]};
            repeat (mem_rng[17:16]) @(posedge cache);
            run_op(op, a, 32'h0, expect_load(op, a[1:0], model[a[9:2]]), 3, 1'b0);
        end
    endtask

    task automatic run_fetches();
        logic [31:0]     rng;
        core_pkg::addr_t pc;
        core_pkg::addr_t exp_pc [$];
        bit              pending;
        bit              strobed;                        // fetch_next is seen on the next edge.
        int              guard;
        rng = xorshift(32'd6365 ^ 32'h5a5a);
        pc = 32'h0;
        fetch_start <= 1'b1;
        fetch_pc    <= pc;
        exp_pc.push_back(pc);
        pending = 1'b1;
        strobed = 1'b0;
        guard = 0;
        for (int c = 0; c < n_fetch || ((pending || strobed) && guard < 40); c++) begin
            @(posedge cache);
            fetch_start <= 1'b0;
            fetch_next  <= 1'b0;
            if (c >= n_fetch) guard++;
            if (instr_valid) begin
                checks++;
                if (exp_pc.size() == 0) begin
                    errors++;
                    $display("instr_valid arrived with no fetch outstanding");
                end else begin
                    pc = exp_pc.pop_front();
                    if (instr !== model[pc[9:2]]) begin
                        errors++;
                        $display("MISMATCH at %0t: instr at pc %h got %h expected %h",
                                 $time, pc, instr, model[pc[9:2]]);
                    end
                end
                pending = 1'b0;
            end
            // the unit takes a strobe once the previous word has come back.
            if (strobed && !pending) begin
                exp_pc.push_back(pc + 32'd4);
                pending = 1'b1;
            end
            strobed = 1'b0;
            rng = xorshift(rng);
            if (c < n_fetch && rng[1:0] == 2'b00) begin
                fetch_next <= 1'b1;                      // ignored by the DUT while pending.
                strobed = 1'b1;
            end
        end
        if (pending || exp_pc.size() != 0) begin
            errors++;
            $display("fetch still outstanding after the fetch test");
        end
    endtask

    initial begin
        repeat ((n_pat + n_rand + 10) * 20 + n_fetch * 20) @(posedge cache);
        $display("timeout: the DUT stopped answering");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int start;
        rstart = 1'b1;
        mem_valid = 1'b0;
        mem_op = core_pkg::mem_none;
        mem_addr = '0;
        mem_wdata = '0;
        fetch_start = 1'b0;
        fetch_pc = '0;
        fetch_next = 1'b0;
        for (int i = 0; i < core_pkg::ram_words; i++) model[i] = '0;
        $readmemh("sim/mem_patterns.hex", pat);
        repeat (4) @(posedge cache);
        rstart <= 1'b0;

        start = errors;
        repeat (6) begin
            @(posedge cache);
            checks++;
            if (!mem_ready || mem_done || instr_valid) begin
                errors++;
                $display("outputs after reset are not idle at %0t", $time);
            end
        end
        report_test("reset", start);

        start = errors;
        run_patterns(0, 5);
        report_test("word store and load", start);
        start = errors;
        run_patterns(6, 15);
        report_test("byte and half stores", start);
        start = errors;
        run_patterns(16, 22);
        report_test("extending loads", start);

        start = errors;
        fork
            run_fetches();
            run_loads_random();
        join
        report_test("loads with fetch traffic", start);

        start = errors;
        run_op(4'd6, 32'h20, 32'h0bad_f00d, 32'h0, 2, 1'b1);
        run_op(4'd1, 32'h20, 32'h0, 32'h0bad_f00d, 2, 1'b1);
        repeat (5) @(posedge cache);
        checks++;
        if (done_count != op_count) begin
            errors++;
            $display("extra mem_done: %0d pulses for %0d operations", done_count, op_count);
        end
        report_test("ignored strobe", start);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
